// ==== hdl/rvExePkg.sv ====
`default_nettype none

package rvExePkg;

	typedef logic [31:0] word_t;     // data, address and immediates
	typedef logic [4:0]  regAddr_t;
	typedef logic [3:0]  byteLane_t; // one enable per byte of a word

	// EQ, LT and LTU only matter for branches
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		SLL  = 4'd2,
		SLT  = 4'd3,
		SLTU = 4'd4,
		XOR  = 4'd5,
		SRL  = 4'd6,
		SRA  = 4'd7,
		OR   = 4'd8,
		AND  = 4'd9,
		EQ   = 4'd10,
		LT   = 4'd11,
		LTU  = 4'd12
	} aluFn_t;

	typedef enum logic [3:0] {
		NONE = 4'd0,
		LB   = 4'd1,
		LH   = 4'd2,
		LW   = 4'd3,
		LBU  = 4'd4,
		LHU  = 4'd5,
		SB   = 4'd6,
		SH   = 4'd7,
		SW   = 4'd8
	} memOp_t;

	typedef enum logic [2:0] {
		MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
	} mulDivOp_t;

	// codes 6 and 7 write back zero
	typedef enum logic [2:0] {
		ALU    = 3'd0,
		LINK   = 3'd1,
		MULDIV = 3'd2,
		UIMM   = 3'd3,
		MEM    = 3'd4,
		AUIPC  = 3'd5
	} wbSel_t;

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu
	import rvExePkg::*;
(
	input  aluFn_t aluFn,
	input  word_t  operandA,
	input  word_t  operandB,
	input  logic   bneq,     // flips the compare for BNE, BGE, BGEU
	output word_t  result,
	output logic   btaken
);

	logic [4:0] shamt;
	logic equal;
	logic lessS;
	logic lessU;
	logic cmp;

	assign shamt = operandB[4:0];
	assign equal = (operandA == operandB);
	assign lessS = ($signed(operandA) < $signed(operandB));
	assign lessU = (operandA < operandB);

	always_comb
	begin
		case (aluFn)
			ADD:       result = operandA + operandB;
			SUB:       result = operandA - operandB;
			SLL:       result = operandA << shamt;
			SLT, LT:   result = {31'b0, lessS};
			SLTU, LTU: result = {31'b0, lessU};
			XOR:       result = operandA ^ operandB;
			SRL:       result = operandA >> shamt;
			SRA:       result = $signed(operandA) >>> shamt; // keeps the sign bit
			OR:        result = operandA | operandB;
			AND:       result = operandA & operandB;
			EQ:        result = {31'b0, equal};
			default:   result = '0;
		endcase
	end

	// branch compare, the set-less-than codes double as compares
	always_comb
	begin
		case (aluFn)
			EQ:        cmp = equal;
			LT, SLT:   cmp = lessS;
			LTU, SLTU: cmp = lessU;
			default:   cmp = 1'b0;
		endcase
	end

	assign btaken = cmp ^ bneq;

endmodule

`default_nettype wire

// ==== hdl/branchUnit.sv ====
`default_nettype none
`timescale 1ns/1ps

module branchUnit
	import rvExePkg::*;
(
	input  word_t pc,
	input  word_t operandA,
	input  word_t bImm,
	input  word_t jImm,
	input  word_t iImm,
	input  logic  btaken,   // compare result from the ALU
	input  logic  isBranch,
	input  logic  jal,
	input  logic  jalr,
	output word_t target,
	output logic  taken
);

	word_t jalrSum;

	assign jalrSum = operandA + iImm;

	always_comb
	begin
		if (jal)
			target = pc + jImm;
		else if (jalr)
			target = {jalrSum[31:1], 1'b0}; // lsb always cleared
		else
			target = pc + bImm;
	end

	// jumps are unconditional
	assign taken = jal | jalr | (isBranch & btaken);

endmodule

`default_nettype wire

// ==== hdl/mulDiv.sv ====
`default_nettype none
`timescale 1ns/1ps

module mulDiv
	import rvExePkg::*;
(
	input  word_t     a,
	input  word_t     b,
	input  mulDivOp_t op,
	output word_t     res
);

	logic [63:0] prodSS;
	logic [63:0] prodSU;
	logic [63:0] prodUU;
	logic signed [31:0] aS;
	logic signed [31:0] bS;
	logic divZero;
	logic overflow;

	assign aS = a;
	assign bS = b;

	// sign-extend to 64 bits, the low 64 bits of the product are then exact
	assign prodSS = {{32{a[31]}}, a} * {{32{b[31]}}, b};
	assign prodSU = {{32{a[31]}}, a} * {32'b0, b};
	assign prodUU = {32'b0, a} * {32'b0, b};

	assign divZero  = (b == 32'b0);
	assign overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff); // most negative / -1

	always_comb
	begin
		case (op)
			MUL:    res = prodUU[31:0];
			MULH:   res = prodSS[63:32];
			MULHSU: res = prodSU[63:32];
			MULHU:  res = prodUU[63:32];
			DIV:
				if (divZero)
					res = '1;
				else if (overflow)
					res = a;
				else
					res = aS / bS;
			DIVU:   res = divZero ? '1 : a / b;
			REM:
				if (divZero)
					res = a;
				else if (overflow)
					res = '0;
				else
					res = aS % bS;
			REMU:   res = divZero ? a : a % b;
			default: res = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/memInterface.sv ====
`default_nettype none
`timescale 1ns/1ps

module memInterface
	import rvExePkg::*;
#(
	parameter int MEM_WORDS = 256
)
(
	input  logic   clk,
	input  logic   nrst,
	input  memOp_t memOp,
	input  word_t  base,
	input  word_t  src,     // store data, or load offset
	input  word_t  sImm,
	output word_t  loadData6,
	output logic   ldMisaligned6,
	output logic   stMisaligned6
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	word_t mem [MEM_WORDS];

	logic isLoad;
	logic isStore;
	logic misaligned;
	word_t addr;
	logic [1:0] offset;
	logic [IDX_W-1:0] wordIdx;
	byteLane_t lane;
	word_t wrData;

	// pipe 6
	memOp_t memOp6;
	logic [1:0] offset6;
	byteLane_t lane6;
	word_t rdWord6;
	word_t laneMask6;
	word_t picked6;

	assign isLoad  = (memOp == LB) || (memOp == LH) || (memOp == LW) ||
		(memOp == LBU) || (memOp == LHU);
	assign isStore = (memOp == SB) || (memOp == SH) || (memOp == SW);

	assign addr    = base + (isStore ? sImm : src);
	assign offset  = addr[1:0];
	assign wordIdx = IDX_W'(addr[31:2] % MEM_WORDS); // wraps at the array depth

	always_comb
	begin
		case (memOp)
			LB, LBU, SB: lane = 4'b0001 << offset;
			LH, LHU, SH: lane = 4'b0011 << offset;
			LW, SW:      lane = 4'b1111;
			default:     lane = 4'b0000;
		endcase
	end

	always_comb
	begin
		case (memOp)
			LH, LHU, SH: misaligned = offset[0];
			LW, SW:      misaligned = |offset;
			default:     misaligned = 1'b0;
		endcase
	end

	assign wrData = src << {offset, 3'b000}; // move store bytes to their lanes

	// misaligned stores are dropped
	always_ff @(posedge clk)
	begin
		if (isStore && !misaligned)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (lane[i])
					mem[wordIdx][8*i +: 8] <= wrData[8*i +: 8];
			end
		end
		rdWord6 <= mem[wordIdx];
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			memOp6        <= NONE;
			offset6       <= 2'b00;
			lane6         <= 4'b0000;
			ldMisaligned6 <= 1'b0;
			stMisaligned6 <= 1'b0;
		end
		else
		begin
			memOp6        <= memOp;
			offset6       <= offset;
			lane6         <= lane;
			ldMisaligned6 <= isLoad & misaligned;
			stMisaligned6 <= isStore & misaligned;
		end
	end

	assign laneMask6 = {{8{lane6[3]}}, {8{lane6[2]}}, {8{lane6[1]}}, {8{lane6[0]}}};
	assign picked6   = (rdWord6 & laneMask6) >> {offset6, 3'b000};

	// extension of the selected bytes
	always_comb
	begin
		case (memOp6)
			LB:      loadData6 = {{24{picked6[7]}}, picked6[7:0]};
			LH:      loadData6 = {{16{picked6[15]}}, picked6[15:0]};
			LW:      loadData6 = picked6;
			LBU:     loadData6 = {24'b0, picked6[7:0]};
			LHU:     loadData6 = {16'b0, picked6[15:0]};
			default: loadData6 = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/exeStage.sv ====
`default_nettype none
`timescale 1ns/1ps

module exeStage
	import rvExePkg::*;
#(
	parameter int MEM_WORDS = 256
)
(
	input  logic      clk,
	input  logic      nrst,
	input  word_t     opA,
	input  word_t     opB,
	input  regAddr_t  rd,
	input  wbSel_t    wbSel,
	input  aluFn_t    aluFn,
	input  logic      we,
	input  word_t     bImm,
	input  word_t     jImm,
	input  word_t     uImm,
	input  word_t     sImm,
	input  logic      bneq,
	input  logic      isBranch,
	input  logic      jal,
	input  logic      jalr,
	input  memOp_t    memOp,
	input  mulDivOp_t mulDivOp,
	input  word_t     pc,
	output word_t     wbData6,
	output regAddr_t  rd6,
	output logic      we6,
	output word_t     target5,
	output logic      bjTaken5,
	output logic      ldMisaligned6,
	output logic      stMisaligned6
);

	// pipe 5
	word_t opA5;
	word_t opB5;
	regAddr_t rd5;
	wbSel_t wbSel5;
	aluFn_t aluFn5;
	logic we5;
	word_t bImm5;
	word_t jImm5;
	word_t uImm5;
	word_t sImm5;
	logic bneq5;
	logic isBranch5;
	logic jal5;
	logic jalr5;
	memOp_t memOp5;
	mulDivOp_t mulDivOp5;
	word_t pc5;

	word_t aluRes5;
	logic btaken5;
	word_t mulDivRes5;

	// pipe 6
	word_t aluRes6;
	word_t mulDivRes6;
	word_t pc6;
	word_t uImm6;
	word_t auipc6;
	wbSel_t wbSel6;
	word_t loadData6;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			opA5      <= '0;
			opB5      <= '0;
			rd5       <= '0;
			wbSel5    <= ALU;
			aluFn5    <= ADD;
			we5       <= 1'b0;
			bImm5     <= '0;
			jImm5     <= '0;
			uImm5     <= '0;
			sImm5     <= '0;
			bneq5     <= 1'b0;
			isBranch5 <= 1'b0;
			jal5      <= 1'b0;
			jalr5     <= 1'b0;
			memOp5    <= NONE;
			mulDivOp5 <= MUL;
			pc5       <= '0;
		end
		else
		begin
			opA5      <= opA;
			opB5      <= opB;
			rd5       <= rd;
			wbSel5    <= wbSel;
			aluFn5    <= aluFn;
			we5       <= we;
			bImm5     <= bImm;
			jImm5     <= jImm;
			uImm5     <= uImm;
			sImm5     <= sImm;
			bneq5     <= bneq;
			isBranch5 <= isBranch;
			jal5      <= jal;
			jalr5     <= jalr;
			memOp5    <= memOp;
			mulDivOp5 <= mulDivOp;
			pc5       <= pc;
		end
	end

	alu uAlu (
		.aluFn    (aluFn5),
		.operandA (opA5),
		.operandB (opB5),
		.bneq     (bneq5),
		.result   (aluRes5),
		.btaken   (btaken5)
	);

	// opB carries the I-immediate for jalr
	branchUnit uBranch (
		.pc       (pc5),
		.operandA (opA5),
		.bImm     (bImm5),
		.jImm     (jImm5),
		.iImm     (opB5),
		.btaken   (btaken5),
		.isBranch (isBranch5),
		.jal      (jal5),
		.jalr     (jalr5),
		.target   (target5),
		.taken    (bjTaken5)
	);

	mulDiv uMulDiv (
		.a   (opA5),
		.b   (opB5),
		.op  (mulDivOp5),
		.res (mulDivRes5)
	);

	memInterface #(
		.MEM_WORDS (MEM_WORDS)
	) uMem (
		.clk           (clk),
		.nrst          (nrst),
		.memOp         (memOp5),
		.base          (opA5),
		.src           (opB5),
		.sImm          (sImm5),
		.loadData6     (loadData6),
		.ldMisaligned6 (ldMisaligned6),
		.stMisaligned6 (stMisaligned6)
	);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			aluRes6    <= '0;
			mulDivRes6 <= '0;
			pc6        <= '0;
			uImm6      <= '0;
			auipc6     <= '0;
			rd6        <= '0;
			we6        <= 1'b0;
			wbSel6     <= ALU;
		end
		else
		begin
			aluRes6    <= aluRes5;
			mulDivRes6 <= mulDivRes5;
			pc6        <= pc5;
			uImm6      <= uImm5;
			auipc6     <= uImm5 + pc5; // auipc sum done a stage early
			rd6        <= rd5;
			we6        <= we5;
			wbSel6     <= wbSel5;
		end
	end

	always_comb
	begin
		case (wbSel6)
			ALU:     wbData6 = aluRes6;
			LINK:    wbData6 = pc6 + 32'd4; // return address
			MULDIV:  wbData6 = mulDivRes6;
			UIMM:    wbData6 = uImm6;
			MEM:     wbData6 = loadData6;
			AUIPC:   wbData6 = auipc6;
			default: wbData6 = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== sim/exeStageTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module exeStageTb
	import rvExePkg::*;
();

	typedef struct packed {
		word_t     opA;
		word_t     opB;
		regAddr_t  rd;
		wbSel_t    wbSel;
		aluFn_t    aluFn;
		logic      we;
		word_t     bImm;
		word_t     jImm;
		word_t     uImm;
		word_t     sImm;
		logic      bneq;
		logic      isBranch;
		logic      jal;
		logic      jalr;
		memOp_t    memOp;
		mulDivOp_t mulDivOp;
		word_t     pc;
		word_t     expWb;
		regAddr_t  expRd;
		logic      expWe;
		word_t     expTarget;
		logic      expTaken;
		logic      chkTarget;  // target5 only means something for jumps and branches
		logic      expLdMis;
		logic      expStMis;
	} testVec_t;

	logic clk;
	logic nrst;
	word_t opA;
	word_t opB;
	regAddr_t rd;
	wbSel_t wbSel;
	aluFn_t aluFn;
	logic we;
	word_t bImm;
	word_t jImm;
	word_t uImm;
	word_t sImm;
	logic bneq;
	logic isBranch;
	logic jal;
	logic jalr;
	memOp_t memOp;
	mulDivOp_t mulDivOp;
	word_t pc;
	word_t wbData6;
	regAddr_t rd6;
	logic we6;
	word_t target5;
	logic bjTaken5;
	logic ldMisaligned6;
	logic stMisaligned6;

	testVec_t vectors[$];
	string names[$];
	bit rowBad[$];
	word_t rngState = 32'h7c72_a6e8;
	int passCount = 0;
	int failCount = 0;
	int cycles = 0;
	int cycleLimit = 20;

	exeStage #(
		.MEM_WORDS (256)
	) UUT (
		.clk           (clk),
		.nrst          (nrst),
		.opA           (opA),
		.opB           (opB),
		.rd            (rd),
		.wbSel         (wbSel),
		.aluFn         (aluFn),
		.we            (we),
		.bImm          (bImm),
		.jImm          (jImm),
		.uImm          (uImm),
		.sImm          (sImm),
		.bneq          (bneq),
		.isBranch      (isBranch),
		.jal           (jal),
		.jalr          (jalr),
		.memOp         (memOp),
		.mulDivOp      (mulDivOp),
		.pc            (pc),
		.wbData6       (wbData6),
		.rd6           (rd6),
		.we6           (we6),
		.target5       (target5),
		.bjTaken5      (bjTaken5),
		.ldMisaligned6 (ldMisaligned6),
		.stMisaligned6 (stMisaligned6)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	function automatic word_t xorshift32(word_t x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// reference ALU, shift amount is the low five bits of b
	function automatic word_t aluModel(aluFn_t fn, word_t a, word_t b);
		logic [4:0] sh;
		word_t r;
		sh = b[4:0];
		case (fn)
			ADD:       r = a + b;
			SUB:       r = a - b;
			SLL:       r = a << sh;
			SLT, LT:   r = {31'b0, $signed(a) < $signed(b)};
			SLTU, LTU: r = {31'b0, a < b};
			XOR:       r = a ^ b;
			SRL:       r = a >> sh;
			SRA:
			begin
				r = a >> sh;
				if (a[31])
					r = r | ~(32'hffff_ffff >> sh); // fill vacated bits with the sign
			end
			OR:        r = a | b;
			AND:       r = a & b;
			EQ:        r = {31'b0, a == b};
			default:   r = '0;
		endcase
		return r;
	endfunction

	function automatic logic branchModel(aluFn_t fn, logic inv, word_t a, word_t b);
		logic c;
		case (fn)
			EQ:      c = (a == b);
			LT:      c = ($signed(a) < $signed(b));
			LTU:     c = (a < b);
			default: c = 1'b0;
		endcase
		return c ^ inv;
	endfunction

	function automatic word_t mulDivModel(mulDivOp_t op, word_t a, word_t b);
		longint sa;
		longint sb;
		longint ub;
		longint p;
		logic [63:0] pu;
		logic ovf;
		sa  = longint'($signed(a));
		sb  = longint'($signed(b));
		ub  = longint'({32'b0, b});
		pu  = {32'b0, a} * {32'b0, b};
		ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (op)
			MUL:    p = sa * sb;
			MULH:   p = (sa * sb) >>> 32;
			MULHSU: p = (sa * ub) >>> 32;
			MULHU:  p = longint'(pu >> 32);
			DIV:    p = (b == 0) ? -1 : (ovf ? sa : sa / sb);
			DIVU:   p = (b == 0) ? -1 : longint'({32'b0, a / b});
			REM:    p = (b == 0) ? sa : (ovf ? 0 : sa % sb);
			default: p = (b == 0) ? sa : longint'({32'b0, a % b}); // REMU
		endcase
		return p[31:0];
	endfunction

	task automatic pushRow(string name, testVec_t r);
		if (r.we)
			r.rd = regAddr_t'(vectors.size() % 31 + 1); // spread over x1..x31
		r.expRd = r.rd;
		r.expWe = r.we;
		vectors.push_back(r);
		names.push_back(name);
		rowBad.push_back(1'b0);
	endtask

	task automatic addAlu(string name, aluFn_t fn, word_t a, word_t b);
		testVec_t r;
		r = '0;
		r.opA   = a;
		r.opB   = b;
		r.aluFn = fn;
		r.wbSel = ALU;
		r.we    = 1'b1;
		r.expWb = aluModel(fn, a, b);
		pushRow(name, r);
	endtask

	task automatic addMulDiv(string name, mulDivOp_t op, word_t a, word_t b);
		testVec_t r;
		r = '0;
		r.opA      = a;
		r.opB      = b;
		r.mulDivOp = op;
		r.wbSel    = MULDIV;
		r.we       = 1'b1;
		r.expWb    = mulDivModel(op, a, b);
		pushRow(name, r);
	endtask

	task automatic addBranch(string name, aluFn_t fn, logic inv, word_t a, word_t b,
		word_t pcVal, word_t off);
		testVec_t r;
		r = '0;
		r.opA       = a;
		r.opB       = b;
		r.aluFn     = fn;
		r.bneq      = inv;
		r.isBranch  = 1'b1;
		r.pc        = pcVal;
		r.bImm      = off;
		r.wbSel     = LINK;
		r.we        = 1'b1;
		r.expWb     = pcVal + 32'd4;
		r.expTarget = pcVal + off;
		r.expTaken  = branchModel(fn, inv, a, b);
		r.chkTarget = 1'b1;
		pushRow(name, r);
	endtask

	task automatic addJump(string name, logic isJalr, word_t a, word_t imm, word_t pcVal);
		testVec_t r;
		r = '0;
		r.opA   = a;
		r.pc    = pcVal;
		r.jal   = ~isJalr;
		r.jalr  = isJalr;
		r.wbSel = LINK;
		r.we    = 1'b1;
		if (isJalr)
		begin
			r.opB       = imm;
			r.expTarget = (a + imm) & 32'hffff_fffe;
		end
		else
		begin
			r.jImm      = imm;
			r.expTarget = pcVal + imm;
		end
		r.expWb     = pcVal + 32'd4;
		r.expTaken  = 1'b1;
		r.chkTarget = 1'b1;
		pushRow(name, r);
	endtask

	task automatic addUpper(string name, wbSel_t sel, word_t u, word_t pcVal);
		testVec_t r;
		r = '0;
		r.uImm  = u;
		r.pc    = pcVal;
		r.wbSel = sel;
		r.we    = 1'b1;
		r.expWb = (sel == UIMM) ? u : u + pcVal;
		pushRow(name, r);
	endtask

	// stores address base+off, loads address base+src
	task automatic addMem(string name, memOp_t op, word_t base, word_t src, word_t off,
		word_t expData, logic ldMis, logic stMis);
		testVec_t r;
		logic isLoad;
		r = '0;
		isLoad     = op inside {LB, LH, LW, LBU, LHU};
		r.memOp    = op;
		r.opA      = base;
		r.opB      = src;
		r.sImm     = off;
		r.wbSel    = isLoad ? MEM : ALU;
		r.we       = isLoad & ~ldMis; // a flagged load writes nothing back
		r.expWb    = expData;
		r.expLdMis = ldMis;
		r.expStMis = stMis;
		pushRow(name, r);
	endtask

	task automatic buildTable();
		aluFn_t fns[13] = '{ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, EQ, LT, LTU};
		mulDivOp_t ops[8] = '{MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
		word_t a;
		word_t b;
		foreach (fns[k])
		begin
			a = nextRandom();
			b = nextRandom();
			addAlu($sformatf("alu_%s", fns[k].name()), fns[k], a, b);
		end
		a = nextRandom();
		b = nextRandom();
		addAlu("sll_by_0", SLL, a, b & 32'hffff_ffe0);
		addAlu("sll_by_31", SLL, a, b | 32'h0000_001f);
		addAlu("srl_by_31", SRL, a | 32'h8000_0000, b | 32'h0000_001f);
		addAlu("sra_by_0", SRA, a | 32'h8000_0000, b & 32'hffff_ffe0);
		addAlu("sra_by_31", SRA, a | 32'h8000_0000, b | 32'h0000_001f);
		foreach (ops[k])
		begin
			a = nextRandom();
			b = nextRandom();
			addMulDiv($sformatf("md_%s", ops[k].name()), ops[k], a, b);
		end
		addMulDiv("div_by_zero", DIV, a, 32'h0);
		addMulDiv("divu_by_zero", DIVU, a, 32'h0);
		addMulDiv("rem_by_zero", REM, a, 32'h0);
		addMulDiv("remu_by_zero", REMU, a, 32'h0);
		addMulDiv("div_overflow", DIV, 32'h8000_0000, 32'hffff_ffff);
		addMulDiv("rem_overflow", REM, 32'h8000_0000, 32'hffff_ffff);
		addMulDiv("div_negative", DIV, 32'hffff_fff9, 32'h2); // truncates toward zero
		addMulDiv("rem_negative", REM, 32'hffff_fff9, 32'h2);
		addBranch("beq_taken", EQ, 1'b0, 32'h1234, 32'h1234, 32'h100, 32'h20);
		addBranch("beq_not_taken", EQ, 1'b0, 32'h1, 32'h2, 32'h104, 32'h40);
		addBranch("bne_taken", EQ, 1'b1, 32'h5, 32'h6, 32'h108, 32'hffff_fff0);
		addBranch("blt_taken", LT, 1'b0, 32'hffff_fffd, 32'h2, 32'h10c, 32'h80);
		addBranch("bge_not_taken", LT, 1'b1, 32'hffff_fffd, 32'h2, 32'h110, 32'h80);
		addBranch("bltu_not_taken", LTU, 1'b0, 32'hffff_fffd, 32'h2, 32'h114, 32'h8);
		addBranch("bgeu_taken", LTU, 1'b1, 32'hffff_fffd, 32'h2, 32'h118, 32'h8);
		addJump("jal", 1'b0, 32'h0, 32'h7fc, 32'h200);
		addJump("jalr_odd_sum", 1'b1, 32'h1001, 32'h10, 32'h204);
		addUpper("lui", UIMM, 32'h1234_5000, 32'h400);
		addUpper("auipc", AUIPC, 32'h1234_5000, 32'h400);
		addMem("sw_word", SW, 32'h40, 32'h1122_3344, 32'h0, 32'h0, 1'b0, 1'b0);
		addMem("lw_after_sw", LW, 32'h40, 32'h0, 32'h0, 32'h1122_3344, 1'b0, 1'b0);
		addMem("sh_upper", SH, 32'h40, 32'h9999_abcd, 32'h2, 32'h0, 1'b0, 1'b0);
		addMem("lw_after_sh", LW, 32'h40, 32'h0, 32'h0, 32'habcd_3344, 1'b0, 1'b0);
		addMem("sb_byte1", SB, 32'h40, 32'hffff_ff5a, 32'h1, 32'h0, 1'b0, 1'b0);
		addMem("lw_after_sb", LW, 32'h40, 32'h0, 32'h0, 32'habcd_5a44, 1'b0, 1'b0);
		addMem("lh_upper", LH, 32'h40, 32'h2, 32'h0, 32'hffff_abcd, 1'b0, 1'b0);
		addMem("lhu_upper", LHU, 32'h40, 32'h2, 32'h0, 32'h0000_abcd, 1'b0, 1'b0);
		addMem("lb_byte1", LB, 32'h40, 32'h1, 32'h0, 32'h0000_005a, 1'b0, 1'b0);
		addMem("lb_byte3", LB, 32'h40, 32'h3, 32'h0, 32'hffff_ffab, 1'b0, 1'b0);
		addMem("lbu_byte3", LBU, 32'h40, 32'h3, 32'h0, 32'h0000_00ab, 1'b0, 1'b0);
		addMem("sh_misaligned", SH, 32'h40, 32'h0000_dead, 32'h1, 32'h0, 1'b0, 1'b1);
		addMem("lw_misaligned", LW, 32'h40, 32'h2, 32'h0, 32'h0, 1'b1, 1'b0);
		addMem("lw_unchanged", LW, 32'h40, 32'h0, 32'h0, 32'habcd_5a44, 1'b0, 1'b0);
	endtask

	task automatic applyRow(testVec_t r);
		opA      = r.opA;
		opB      = r.opB;
		rd       = r.rd;
		wbSel    = r.wbSel;
		aluFn    = r.aluFn;
		we       = r.we;
		bImm     = r.bImm;
		jImm     = r.jImm;
		uImm     = r.uImm;
		sImm     = r.sImm;
		bneq     = r.bneq;
		isBranch = r.isBranch;
		jal      = r.jal;
		jalr     = r.jalr;
		memOp    = r.memOp;
		mulDivOp = r.mulDivOp;
		pc       = r.pc;
	endtask

	task automatic printMismatch(string test, string field, word_t exp, word_t act);
		$display("MISMATCH %s %s: expected %h, actual %h", test, field, exp, act);
	endtask

	task automatic checkReset();
		bit bad;
		bad = 1'b0;
		if (we6 !== 1'b0)
		begin
			printMismatch("reset", "we6", 32'h0, {31'b0, we6});
			bad = 1'b1;
		end
		if (bjTaken5 !== 1'b0)
		begin
			printMismatch("reset", "bjTaken5", 32'h0, {31'b0, bjTaken5});
			bad = 1'b1;
		end
		if (ldMisaligned6 !== 1'b0 || stMisaligned6 !== 1'b0)
		begin
			printMismatch("reset", "misalign flags", 32'h0, {30'b0, ldMisaligned6, stMisaligned6});
			bad = 1'b1;
		end
		if (bad)
			failCount++;
		else
			passCount++;
		$display("test reset: %s", bad ? "failed" : "passed");
	endtask

	// pipe 5 outputs, one edge after the row was captured
	task automatic checkBranch(int i);
		testVec_t r;
		r = vectors[i];
		if (bjTaken5 !== r.expTaken)
		begin
			printMismatch(names[i], "bjTaken5", {31'b0, r.expTaken}, {31'b0, bjTaken5});
			rowBad[i] = 1'b1;
		end
		if (r.chkTarget && target5 !== r.expTarget)
		begin
			printMismatch(names[i], "target5", r.expTarget, target5);
			rowBad[i] = 1'b1;
		end
	endtask

	// pipe 6 outputs, the last check of a row
	task automatic checkWriteback(int i);
		testVec_t r;
		r = vectors[i];
		if (we6 !== r.expWe)
		begin
			printMismatch(names[i], "we6", {31'b0, r.expWe}, {31'b0, we6});
			rowBad[i] = 1'b1;
		end
		if (rd6 !== r.expRd)
		begin
			printMismatch(names[i], "rd6", {27'b0, r.expRd}, {27'b0, rd6});
			rowBad[i] = 1'b1;
		end
		if (r.expWe && wbData6 !== r.expWb)
		begin
			printMismatch(names[i], "wbData6", r.expWb, wbData6);
			rowBad[i] = 1'b1;
		end
		if (ldMisaligned6 !== r.expLdMis)
		begin
			printMismatch(names[i], "ldMisaligned6", {31'b0, r.expLdMis}, {31'b0, ldMisaligned6});
			rowBad[i] = 1'b1;
		end
		if (stMisaligned6 !== r.expStMis)
		begin
			printMismatch(names[i], "stMisaligned6", {31'b0, r.expStMis}, {31'b0, stMisaligned6});
			rowBad[i] = 1'b1;
		end
		if (rowBad[i])
			failCount++;
		else
			passCount++;
		$display("test %s: %s", names[i], rowBad[i] ? "failed" : "passed");
	endtask

	initial
	begin
		testVec_t idle;
		testVec_t busy;
		int n;
		idle = '0;
		// live traffic while in reset, so unreset pipe registers would show up
		busy = '0;
		busy.we    = 1'b1;
		busy.jal   = 1'b1;
		busy.memOp = SW;
		busy.sImm  = 32'h1; // misaligned, never reaches the array
		nrst = 1'b0;
		applyRow(busy);
		buildTable();
		n = vectors.size();
		cycleLimit = n + 20;
		repeat (2) @(posedge clk);
		#1 nrst = 1'b1;
		applyRow(idle);
		checkReset();
		// row c goes in now, its branch result shows one edge later, writeback two
		for (int c = 0; c < n + 2; c++)
		begin
			@(posedge clk);
			#1;
			if (c >= 1 && c <= n)
				checkBranch(c - 1);
			if (c >= 2)
				checkWriteback(c - 2);
			if (c < n)
				applyRow(vectors[c]);
			else
				applyRow(idle);
		end
		$display("tests passed: %0d, tests failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > cycleLimit)
		begin
			$display("TIMEOUT: run did not finish within %0d cycles", cycleLimit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/rvExePkg.sv
hdl/alu.sv
hdl/branchUnit.sv
hdl/mulDiv.sv
hdl/memInterface.sv
hdl/exeStage.sv
sim/exeStageTb.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench

VERILATOR  ?= verilator
TOP        ?= exeStageTb
RTL_TOP    ?= exeStage
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
